// ==== logic/sha_pkg.sv ====
`default_nettype none

package sha_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Stream payloads

	// Big-endian message or state word
	typedef logic [31:0] word_t;

	// Sender-chosen message tag, returned with the digest
	typedef logic [3:0] tag_t;

	// One input beat
	// Valid bytes are counted from the most significant byte
	typedef struct packed {
		word_t      data;
		logic [2:0] nbytes;
		logic       last;
		tag_t       tag;
	} msg_beat_t;

	// H0 in the top word, H7 in the bottom word
	typedef logic [255:0] digest_t;

	typedef struct packed {
		digest_t digest;
		tag_t    tag;
	} digest_beat_t;

	////////////////////////////////////////////////////////////////////////////
	// Hub sizes

	localparam int NUM_ENGINES = 4;
	localparam int ENG_IDX_W = 2;
	localparam int IN_FIFO_DEPTH = 16;
	localparam int OUT_FIFO_DEPTH = 4;

	////////////////////////////////////////////////////////////////////////////
	// SHA-256 constants, index 0 first

	localparam logic [0:63][31:0] SHA_K = {
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// Initial hash words H0 to H7
	localparam logic [0:7][31:0] SHA_IV = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

endpackage

`default_nettype wire

// ==== logic/sha_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module sha_fifo #(
	parameter type payload_t = logic,
	parameter int DEPTH = 4
) (
	input wire clk,
	input wire rst_n,
	input wire wr_valid,
	output logic wr_ready,
	input wire payload_t wr_data,
	output logic rd_valid,
	input wire rd_ready,
	output payload_t rd_data
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// Circular storage
	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	// Handshake flags straight from the occupancy count
	assign wr_ready = count != CNT_W'(DEPTH);
	assign rd_valid = count != '0;
	assign rd_data = mem[rd_ptr];
	assign push = wr_valid && wr_ready;
	assign pop = rd_valid && rd_ready;

	// Wrap at DEPTH, works for depths that are not a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			// Simultaneous push and pop leaves the count alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= wr_data;
	end

endmodule

`default_nettype wire

// ==== logic/sha_dispatch.sv ====
`timescale 1ns/100ps
`default_nettype none

module sha_dispatch (
	input wire clk,
	input wire rst_n,
	input wire in_valid,
	output logic in_ready,
	input wire sha_pkg::msg_beat_t in_beat,
	output logic [sha_pkg::NUM_ENGINES-1:0] eng_in_valid,
	input wire [sha_pkg::NUM_ENGINES-1:0] eng_in_ready,
	output sha_pkg::msg_beat_t eng_in_beat
);

	import sha_pkg::*;

	// FIFO head
	logic head_valid;
	logic head_pop;
	msg_beat_t head_beat;

	// Engine selection state
	logic locked;
	logic [ENG_IDX_W-1:0] sel;
	logic [ENG_IDX_W-1:0] rr_ptr;
	logic pick_found;
	logic [ENG_IDX_W-1:0] pick_idx;
	logic [ENG_IDX_W-1:0] target;
	logic target_ok;

	sha_fifo #(
		.payload_t (msg_beat_t),
		.DEPTH     (IN_FIFO_DEPTH)
	) in_fifo_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_valid (in_valid),
		.wr_ready (in_ready),
		.wr_data  (in_beat),
		.rd_valid (head_valid),
		.rd_ready (head_pop),
		.rd_data  (head_beat)
	);

	////////////////////////////////////////////////////////////////////////////
	// Round-robin search, starting after the last engine used

	always_comb begin
		logic [ENG_IDX_W-1:0] cand;
		pick_found = 1'b0;
		pick_idx = rr_ptr;
		for (int i = 1; i <= NUM_ENGINES; i++) begin
			cand = ENG_IDX_W'((int'(rr_ptr) + i) % NUM_ENGINES);
			if (!pick_found && eng_in_ready[cand]) begin
				pick_found = 1'b1;
				pick_idx = cand;
			end
		end
	end

	// Mid-message the locked engine is the only target
	assign target = locked ? sel : pick_idx;
	assign target_ok = locked || pick_found;

	// Shared beat bus, one-hot valid
	always_comb begin
		eng_in_valid = '0;
		if (head_valid && target_ok)
			eng_in_valid[target] = 1'b1;
	end

	assign eng_in_beat = head_beat;
	assign head_pop = head_valid && target_ok && eng_in_ready[target];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			locked <= 1'b0;
			sel <= '0;
			// First message goes to engine 0
			rr_ptr <= ENG_IDX_W'(NUM_ENGINES - 1);
		end else if (head_pop) begin
			sel <= target;
			locked <= !head_beat.last;
			// Advance the pointer once the message is complete
			if (head_beat.last)
				rr_ptr <= target;
		end
	end

endmodule

`default_nettype wire

// ==== logic/sha_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module sha_engine (
	input wire clk,
	input wire rst_n,
	input wire in_valid,
	output logic in_ready,
	input wire sha_pkg::msg_beat_t in_beat,
	output logic out_valid,
	input wire out_ready,
	output sha_pkg::digest_beat_t out_digest
);

	import sha_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_FILL,
		S_PAD,
		S_COMP,
		S_ACC,
		S_EXTRA,
		S_HOLD
	} state_t;

	state_t state;

	// Control
	logic [31:0] byte_cnt;
	logic [4:0] word_cnt;
	logic [5:0] round;
	logic msg_done;
	logic pad_done;
	logic final_blk;

	// Datapath
	tag_t tag_q;
	word_t wv [8];
	word_t hv [8];
	word_t w [16];

	// Beat intake
	logic take;
	logic [31:0] byte_base;
	logic [31:0] byte_next;
	logic [4:0] word_base;
	logic [4:0] word_next;
	logic blk_full;
	word_t beat_mask;

	// Padding position and bit length
	logic [3:0] pad_word;
	logic [1:0] pad_byte;
	word_t len_hi;
	word_t len_lo;

	// Round terms
	word_t t1;
	word_t t2;
	word_t w_new;

	function automatic word_t rotr(input word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic word_t big_s0(input word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic word_t big_s1(input word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic word_t small_s0(input word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t small_s1(input word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	assign in_ready = (state == S_IDLE) || (state == S_FILL);
	assign out_valid = state == S_HOLD;
	assign out_digest = '{
		digest: {hv[0], hv[1], hv[2], hv[3], hv[4], hv[5], hv[6], hv[7]},
		tag: tag_q
	};

	////////////////////////////////////////////////////////////////////////////
	// Intake and round arithmetic

	always_comb begin
		take = in_valid && in_ready;
		// A new message counts from zero
		byte_base = (state == S_IDLE) ? '0 : byte_cnt;
		word_base = (state == S_IDLE) ? '0 : word_cnt;
		byte_next = byte_base + 32'(in_beat.nbytes);
		word_next = word_base + 5'(in_beat.nbytes != 3'd0);
		// A short last beat in word 15 leaves room for padding in this block
		blk_full = (word_next == 5'd16) && (byte_next[1:0] == 2'd0);
		// Clear the unused low bytes of a short beat
		beat_mask = ~(32'hffff_ffff >> {in_beat.nbytes, 3'b000});
		pad_word = byte_cnt[5:2];
		pad_byte = byte_cnt[1:0];
		len_hi = {29'd0, byte_cnt[31:29]};
		len_lo = {byte_cnt[28:0], 3'd0};
		// wv[0] is a and wv[7] is h
		t1 = wv[7] + big_s1(wv[4]) + ((wv[4] & wv[5]) ^ (~wv[4] & wv[6]))
			+ SHA_K[round] + w[0];
		t2 = big_s0(wv[0]) + ((wv[0] & wv[1]) ^ (wv[0] & wv[2]) ^ (wv[1] & wv[2]));
		// Next schedule word, from W[t-2], W[t-7], W[t-15] and W[t-16]
		w_new = small_s1(w[14]) + w[9] + small_s0(w[1]) + w[0];
	end

	////////////////////////////////////////////////////////////////////////////
	// State machine

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			byte_cnt <= '0;
			word_cnt <= '0;
			round <= '0;
			msg_done <= 1'b0;
			pad_done <= 1'b0;
			final_blk <= 1'b0;
		end else begin
			case (state)
				S_IDLE, S_FILL: begin
					if (take) begin
						byte_cnt <= byte_next;
						word_cnt <= word_next;
						msg_done <= in_beat.last;
						// Full block goes first, even on the last beat
						if (blk_full)
							state <= S_COMP;
						else if (in_beat.last)
							state <= S_PAD;
						else
							state <= S_FILL;
					end
				end
				S_PAD: begin
					pad_done <= 1'b1;
					final_blk <= byte_cnt[5:0] <= 6'd55;
					state <= S_COMP;
				end
				S_COMP: begin
					// Wraps back to 0 for the next block
					round <= round + 1'b1;
					if (round == 6'd63)
						state <= S_ACC;
				end
				S_ACC: begin
					if (final_blk) begin
						state <= S_HOLD;
					end else if (!msg_done) begin
						word_cnt <= '0;
						state <= S_FILL;
					end else if (pad_done) begin
						state <= S_EXTRA;
					end else begin
						// Message ended on a block boundary
						state <= S_PAD;
					end
				end
				S_EXTRA: begin
					final_blk <= 1'b1;
					state <= S_COMP;
				end
				S_HOLD: begin
					if (out_ready) begin
						msg_done <= 1'b0;
						pad_done <= 1'b0;
						final_blk <= 1'b0;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Block buffer, schedule and hash state

	always_ff @(posedge clk) begin
		case (state)
			S_IDLE, S_FILL: begin
				if (take) begin
					if (state == S_IDLE) begin
						tag_q <= in_beat.tag;
						for (int i = 0; i < 8; i++)
							hv[i] <= SHA_IV[i];
					end
					if (in_beat.nbytes != 3'd0)
						w[word_base[3:0]] <= in_beat.data & beat_mask;
					if (blk_full)
						wv <= hv;
				end
			end
			S_PAD: begin
				// 0x80 after the last byte, zeros behind it
				for (int i = 0; i < 16; i++) begin
					if (i > int'(pad_word))
						w[i] <= '0;
					else if (i == int'(pad_word) && pad_byte == 2'd0)
						w[i] <= 32'h8000_0000;
					else if (i == int'(pad_word))
						w[i] <= w[i] | (32'h8000_0000 >> {pad_byte, 3'b000});
				end
				if (byte_cnt[5:0] <= 6'd55) begin
					w[14] <= len_hi;
					w[15] <= len_lo;
				end
				wv <= hv;
			end
			S_EXTRA: begin
				// Length-only block
				for (int i = 0; i < 14; i++)
					w[i] <= '0;
				w[14] <= len_hi;
				w[15] <= len_lo;
				wv <= hv;
			end
			S_COMP: begin
				for (int i = 0; i < 15; i++)
					w[i] <= w[i + 1];
				w[15] <= w_new;
				wv[0] <= t1 + t2;
				wv[1] <= wv[0];
				wv[2] <= wv[1];
				wv[3] <= wv[2];
				wv[4] <= wv[3] + t1;
				wv[5] <= wv[4];
				wv[6] <= wv[5];
				wv[7] <= wv[6];
			end
			S_ACC: begin
				for (int i = 0; i < 8; i++)
					hv[i] <= hv[i] + wv[i];
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/sha_collect.sv ====
`timescale 1ns/100ps
`default_nettype none

module sha_collect (
	input wire clk,
	input wire rst_n,
	input wire [sha_pkg::NUM_ENGINES-1:0] eng_out_valid,
	output logic [sha_pkg::NUM_ENGINES-1:0] eng_out_ready,
	input wire sha_pkg::digest_beat_t eng_out_digest [sha_pkg::NUM_ENGINES],
	output logic out_valid,
	input wire out_ready,
	output sha_pkg::digest_beat_t out_digest
);

	import sha_pkg::*;

	logic fifo_ready;
	logic gnt_found;
	logic [ENG_IDX_W-1:0] gnt_idx;
	logic [ENG_IDX_W-1:0] last_gnt;

	////////////////////////////////////////////////////////////////////////////
	// Next valid engine after the last grant

	always_comb begin
		logic [ENG_IDX_W-1:0] cand;
		gnt_found = 1'b0;
		gnt_idx = last_gnt;
		for (int i = 1; i <= NUM_ENGINES; i++) begin
			cand = ENG_IDX_W'((int'(last_gnt) + i) % NUM_ENGINES);
			if (!gnt_found && eng_out_valid[cand]) begin
				gnt_found = 1'b1;
				gnt_idx = cand;
			end
		end
	end

	// Grant only with room in the output FIFO
	always_comb begin
		eng_out_ready = '0;
		if (gnt_found && fifo_ready)
			eng_out_ready[gnt_idx] = 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			last_gnt <= ENG_IDX_W'(NUM_ENGINES - 1);
		else if (gnt_found && fifo_ready)
			last_gnt <= gnt_idx;
	end

	sha_fifo #(
		.payload_t (digest_beat_t),
		.DEPTH     (OUT_FIFO_DEPTH)
	) out_fifo_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_valid (gnt_found),
		.wr_ready (fifo_ready),
		.wr_data  (eng_out_digest[gnt_idx]),
		.rd_valid (out_valid),
		.rd_ready (out_ready),
		.rd_data  (out_digest)
	);

endmodule

`default_nettype wire

// ==== logic/sha_hub.sv ====
`timescale 1ns/100ps
`default_nettype none

module sha_hub (
	input wire clk,
	input wire rst_n,
	input wire in_valid,
	output wire in_ready,
	input wire sha_pkg::msg_beat_t in_beat,
	output wire out_valid,
	input wire out_ready,
	output wire sha_pkg::digest_beat_t out_digest
);

	import sha_pkg::*;

	// Dispatcher to engines
	wire [NUM_ENGINES-1:0] eng_in_valid;
	wire [NUM_ENGINES-1:0] eng_in_ready;
	wire msg_beat_t eng_in_beat;

	// Engines to collector
	wire [NUM_ENGINES-1:0] eng_out_valid;
	wire [NUM_ENGINES-1:0] eng_out_ready;
	wire digest_beat_t eng_out_digest [NUM_ENGINES];

	sha_dispatch dispatch_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.in_beat      (in_beat),
		.eng_in_valid (eng_in_valid),
		.eng_in_ready (eng_in_ready),
		.eng_in_beat  (eng_in_beat)
	);

	////////////////////////////////////////////////////////////////////////////
	// Engine array, all on the shared beat bus

	for (genvar n = 0; n < NUM_ENGINES; n++) begin : g_eng
		sha_engine engine_i (
			.clk        (clk),
			.rst_n      (rst_n),
			.in_valid   (eng_in_valid[n]),
			.in_ready   (eng_in_ready[n]),
			.in_beat    (eng_in_beat),
			.out_valid  (eng_out_valid[n]),
			.out_ready  (eng_out_ready[n]),
			.out_digest (eng_out_digest[n])
		);
	end

	sha_collect collect_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.eng_out_valid  (eng_out_valid),
		.eng_out_ready  (eng_out_ready),
		.eng_out_digest (eng_out_digest),
		.out_valid      (out_valid),
		.out_ready      (out_ready),
		.out_digest     (out_digest)
	);

endmodule

`default_nettype wire

// ==== test/sha_hub_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module sha_hub_sva (
	input wire clk,
	input wire rst_n,
	input wire in_ready,
	input wire out_valid,
	input wire out_ready,
	input wire sha_pkg::digest_beat_t out_digest,
	input wire [sha_pkg::NUM_ENGINES-1:0] eng_out_valid,
	input wire [sha_pkg::NUM_ENGINES-1:0] eng_out_ready
);

	// Set once any engine hands a digest to the collector
	logic digest_seen;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			digest_seen <= 1'b0;
		else if (|(eng_out_valid & eng_out_ready))
			digest_seen <= 1'b1;
	end

	// Output beat frozen while the receiver stalls
	out_stable: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_digest))
		else $error("out_valid or out_digest changed while out_ready was low");

	// Quiet output in reset and before the first finished message
	out_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else $error("out_valid high during reset");

	out_after_digest: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> digest_seen)
		else $error("out_valid high before any engine finished");

	in_ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> in_ready)
		else $error("in_ready low right after reset release");

endmodule

bind sha_hub sha_hub_sva sva_i (
	.clk           (clk),
	.rst_n         (rst_n),
	.in_ready      (in_ready),
	.out_valid     (out_valid),
	.out_ready     (out_ready),
	.out_digest    (out_digest),
	.eng_out_valid (eng_out_valid),
	.eng_out_ready (eng_out_ready)
);

`default_nettype wire

// ==== include/sha_ref_model.svh ====
`ifndef SHA_REF_MODEL_SVH
`define SHA_REF_MODEL_SVH

function automatic logic [31:0] sha_ref_rotr(input logic [31:0] x, input int n);
	return (x >> n) | (x << (32 - n));
endfunction

////////////////////////////////////////////////////////////////////////////
// Whole-message SHA-256 over a byte queue

function automatic sha_pkg::digest_t sha_ref_digest(input byte unsigned msg [$]);
	byte unsigned pad_q [$];
	logic [63:0] bit_len;
	logic [31:0] w [64];
	logic [31:0] h [8];
	logic [31:0] v [8];
	logic [31:0] s0;
	logic [31:0] s1;
	logic [31:0] t1;
	logic [31:0] t2;
	pad_q = msg;
	bit_len = 64'(msg.size()) * 64'd8;
	// 0x80, zeros up to 56 mod 64, then the bit length
	pad_q.push_back(8'h80);
	while (pad_q.size() % 64 != 56)
		pad_q.push_back(8'h00);
	for (int i = 7; i >= 0; i--)
		pad_q.push_back(bit_len[8*i +: 8]);
	for (int i = 0; i < 8; i++)
		h[i] = sha_pkg::SHA_IV[i];
	for (int blk = 0; blk < pad_q.size() / 64; blk++) begin
		for (int t = 0; t < 16; t++)
			w[t] = {pad_q[64*blk + 4*t], pad_q[64*blk + 4*t + 1],
				pad_q[64*blk + 4*t + 2], pad_q[64*blk + 4*t + 3]};
		// Full schedule held here
		for (int t = 16; t < 64; t++) begin
			s0 = sha_ref_rotr(w[t-15], 7) ^ sha_ref_rotr(w[t-15], 18) ^ (w[t-15] >> 3);
			s1 = sha_ref_rotr(w[t-2], 17) ^ sha_ref_rotr(w[t-2], 19) ^ (w[t-2] >> 10);
			w[t] = w[t-16] + s0 + w[t-7] + s1;
		end
		v = h;
		for (int t = 0; t < 64; t++) begin
			s1 = sha_ref_rotr(v[4], 6) ^ sha_ref_rotr(v[4], 11) ^ sha_ref_rotr(v[4], 25);
			t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + sha_pkg::SHA_K[t] + w[t];
			s0 = sha_ref_rotr(v[0], 2) ^ sha_ref_rotr(v[0], 13) ^ sha_ref_rotr(v[0], 22);
			t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
			for (int i = 7; i > 0; i--)
				v[i] = v[i-1];
			v[4] = v[4] + t1;
			v[0] = t1 + t2;
		end
		for (int i = 0; i < 8; i++)
			h[i] = h[i] + v[i];
	end
	return {h[0], h[1], h[2], h[3], h[4], h[5], h[6], h[7]};
endfunction

`endif

// ==== test/sha_hub_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module sha_hub_tb;

	import sha_pkg::*;

	`include "sha_ref_model.svh"

	typedef byte unsigned byte_q_t [$];

	localparam int SEED = 91588;
	localparam int NUM_TAGS = 1 << $bits(tag_t);
	localparam int NUM_RANDOM = 40;
	localparam int NUM_BACKPRESSURE = 16;
	localparam int MAX_LEN = 200;
	localparam int CYCLES_PER_BLOCK = 200;
	localparam int WATCHDOG_MARGIN = 2000;
	localparam int DRAIN_CYCLES = 50;

	// Published digests for "", "abc" and the 56-byte two-block vector
	localparam digest_t DIGEST_EMPTY =
		256'he3b0c442_98fc1c14_9afbf4c8_996fb924_27ae41e4_649b934c_a495991b_7852b855;
	localparam digest_t DIGEST_ABC =
		256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad;
	localparam digest_t DIGEST_448 =
		256'h248d6a61_d20638b8_e5c02693_0c3e6039_a33ce459_64ff2167_f6ecedd4_19db06c1;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	msg_beat_t in_beat;
	logic out_valid;
	logic out_ready;
	digest_beat_t out_digest;

	// Scoreboard, one slot per tag
	digest_t exp_digest [NUM_TAGS];
	logic exp_pending [NUM_TAGS];
	int pending_count;
	tag_t next_tag;
	// Random out_ready when set
	logic backpressure;
	int rand_len [NUM_RANDOM + NUM_BACKPRESSURE];

	sha_hub sha_hub_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_beat    (in_beat),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_digest (out_digest)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reporting

	task automatic stop_run();
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic report_mismatch(input string what);
		$display("FAILED at %0t: %s", $time, what);
		stop_run();
	endtask

	task automatic run_watchdog(input int cycles);
		repeat (cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles, %0d digests still outstanding",
			cycles, pending_count);
		stop_run();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Message helpers

	function automatic byte_q_t to_bytes(input string s);
		byte_q_t q;
		for (int i = 0; i < s.len(); i++)
			q.push_back(s[i]);
		return q;
	endfunction

	function automatic byte_q_t random_bytes(input int len);
		byte_q_t q;
		for (int i = 0; i < len; i++)
			q.push_back(8'($urandom));
		return q;
	endfunction

	// Padded length in 64-byte blocks
	function automatic int block_count(input int len);
		return (len + 8) / 64 + 1;
	endfunction

	// Hold the beat until a clock edge sees in_ready high
	task automatic drive_beat(input msg_beat_t b);
		logic accepted;
		in_beat = b;
		in_valid = 1'b1;
		accepted = 1'b0;
		while (!accepted) begin
			// in_ready only moves on clock edges
			accepted = in_ready;
			@(posedge clk);
			#2;
		end
		in_valid = 1'b0;
	endtask

	task automatic send_message(input byte_q_t msg, input digest_t expected);
		int nb;
		int pos;
		tag_t tag;
		msg_beat_t b;
		tag = next_tag;
		next_tag = next_tag + 4'd1;
		// A tag is reused only after its digest came back
		while (exp_pending[tag]) begin
			@(posedge clk);
			#2;
		end
		exp_digest[tag] = expected;
		exp_pending[tag] = 1'b1;
		pending_count++;
		pos = 0;
		// Empty message still sends one beat with zero bytes
		do begin
			nb = msg.size() - pos;
			if (nb > 4)
				nb = 4;
			b.data = '0;
			for (int i = 0; i < nb; i++)
				b.data[31 - 8*i -: 8] = msg[pos + i];
			b.nbytes = 3'(nb);
			b.last = (pos + nb) == msg.size();
			b.tag = tag;
			drive_beat(b);
			pos += nb;
		end while (pos < msg.size());
	endtask

	// Each digest must match a pending tag exactly once
	task automatic check_digest(input digest_beat_t d);
		assert (exp_pending[d.tag]) else begin
			$display("Digest with tag %0d arrived at %0t but none was expected",
				d.tag, $time);
			stop_run();
		end
		assert (d.digest == exp_digest[d.tag]) else
			report_mismatch($sformatf("tag %0d digest %h, expected %h",
				d.tag, d.digest, exp_digest[d.tag]));
		exp_pending[d.tag] = 1'b0;
		pending_count--;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output side, ready driven and digest taken 2 ns after the edge

	initial begin
		wait (rst_n == 1'b1);
		forever begin
			@(posedge clk);
			#2;
			out_ready = backpressure ? ($urandom % 2 == 0) : 1'b1;
			if (out_valid && out_ready)
				check_digest(out_digest);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int total_blocks;
		int limit_cycles;
		byte_q_t msg;
		void'($urandom(SEED));
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_beat = '0;
		out_ready = 1'b0;
		backpressure = 1'b0;
		next_tag = '0;
		pending_count = 0;
		for (int i = 0; i < NUM_TAGS; i++)
			exp_pending[i] = 1'b0;
		// Lengths drawn up front, padding corner cases first
		for (int i = 0; i < NUM_RANDOM + NUM_BACKPRESSURE; i++)
			rand_len[i] = int'($urandom_range(0, MAX_LEN));
		rand_len[0] = 55;
		rand_len[1] = 56;
		rand_len[2] = 63;
		rand_len[3] = 64;
		// Published vectors take 4 blocks
		total_blocks = 4;
		for (int i = 0; i < NUM_RANDOM + NUM_BACKPRESSURE; i++)
			total_blocks += block_count(rand_len[i]);
		limit_cycles = total_blocks * CYCLES_PER_BLOCK + WATCHDOG_MARGIN + DRAIN_CYCLES;
		fork
			run_watchdog(limit_cycles);
		join_none
		repeat (8) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(posedge clk);
		#2;
		assert (in_ready) else begin
			$display("in_ready is low after reset was released");
			stop_run();
		end
		send_message(to_bytes(""), DIGEST_EMPTY);
		send_message(to_bytes("abc"), DIGEST_ABC);
		send_message(to_bytes("abcdbcdecdefdefgefghfghighijhijkijkljklmklmnlmnomnopnopq"),
			DIGEST_448);
		// Back to back, several engines busy at once
		for (int i = 0; i < NUM_RANDOM; i++) begin
			msg = random_bytes(rand_len[i]);
			send_message(msg, sha_ref_digest(msg));
		end
		// Stall the output about half the time
		backpressure = 1'b1;
		for (int i = NUM_RANDOM; i < NUM_RANDOM + NUM_BACKPRESSURE; i++) begin
			msg = random_bytes(rand_len[i]);
			send_message(msg, sha_ref_digest(msg));
		end
		while (pending_count != 0) begin
			@(posedge clk);
			#2;
		end
		// Any digest still arriving now is a duplicate
		backpressure = 1'b0;
		repeat (DRAIN_CYCLES) @(posedge clk);
		#2;
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sha_hub.f ====
+incdir+include
logic/sha_pkg.sv
logic/sha_fifo.sv
logic/sha_dispatch.sv
logic/sha_engine.sv
logic/sha_collect.sv
logic/sha_hub.sv
test/sha_hub_sva.sv
test/sha_hub_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SHA-256 hub testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module sha_hub_tb -f sha_hub.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vsha_hub_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1
